// ==== src/aimbot_pkg.sv ====
`default_nettype none

package aimbot_pkg;

    // Camera and display geometry, in pixels and lines.
    localparam int CAM_W     = 8;
    localparam int CAM_H     = 4;
    localparam int DISP_W    = 2 * CAM_W;             // Both cameras side by side.
    localparam int FRAME_PIX = CAM_W * CAM_H;

    // Shared frame memory.
    localparam int MEM_DEPTH = 64;
    localparam int ADDR_W    = 6;
    localparam int CAM2_BASE = 32;                    // Camera 1 owns words 0 to 31.

    // Display timing.
    localparam int PIX_DIV   = 4;                     // Clocks per display pixel.
    localparam int H_BLANK   = 4;
    localparam int V_BLANK   = 1;
    localparam int PIPE_LAT  = 2 * PIX_DIV;           // Counter to display output delay.

    typedef enum logic {
        PH_HIGH,
        PH_LOW
    } byte_phase_t;

    typedef enum logic [1:0] {
        GNT_NONE,
        GNT_CAM1,
        GNT_CAM2,
        GNT_DISP
    } grant_t;

endpackage : aimbot_pkg

`default_nettype wire

// ==== src/cam_packer.sv ====
`timescale 1ns/1ps
`default_nettype none

module cam_packer
    import aimbot_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               vsync,
    input  wire               byte_valid,
    input  wire  [7:0]        byte_data,
    input  wire  [ADDR_W-1:0] region_base,
    output logic              wr_stb,
    output logic [ADDR_W-1:0] wr_addr,
    output logic [15:0]       wr_data
);

    byte_phase_t       phase;
    logic [7:0]        hi_byte;
    logic [ADDR_W-1:0] pix_cnt;
    logic              pix_done;
    logic              frame_full;

    assign pix_done   = byte_valid && (phase == PH_LOW);          // Second byte of a pixel.
    assign frame_full = (pix_cnt >= ADDR_W'(FRAME_PIX));

    always_ff @(posedge clk) begin
        if (rst) begin
            phase   <= PH_HIGH;
            pix_cnt <= '0;
            wr_stb  <= 1'b0;
        end else begin
            wr_stb <= 1'b0;
            if (vsync) begin
                phase   <= PH_HIGH;
                pix_cnt <= '0;
            end else if (byte_valid) begin
                phase <= (phase == PH_HIGH) ? PH_LOW : PH_HIGH;
                if (pix_done && !frame_full) begin                // Extra pixels are dropped.
                    wr_stb  <= 1'b1;
                    pix_cnt <= pix_cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_valid && phase == PH_HIGH) begin
            hi_byte <= byte_data;
        end
        if (pix_done) begin
            wr_data <= {hi_byte, byte_data};
            wr_addr <= region_base + pix_cnt;
        end
    end

endmodule : cam_packer

`default_nettype wire

// ==== src/frame_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_arbiter
    import aimbot_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    input  wire               cam1_stb,
    input  wire  [ADDR_W-1:0] cam1_addr,
    input  wire  [15:0]       cam1_data,
    input  wire               cam2_stb,
    input  wire  [ADDR_W-1:0] cam2_addr,
    input  wire  [15:0]       cam2_data,
    input  wire               disp_stb,
    input  wire  [ADDR_W-1:0] disp_addr,
    output logic              rd_valid,
    output logic [15:0]       rd_data,
    output logic              mem_we,
    output logic [ADDR_W-1:0] mem_addr,
    output logic [15:0]       mem_wdata,
    input  wire  [15:0]       mem_rdata,
    output logic              err
);

    // Slot 0 is camera 1, slot 1 camera 2, slot 2 the display.
    logic [2:0]        req_stb;
    logic [ADDR_W-1:0] req_addr  [3];
    logic [15:0]       req_data  [2];
    logic [2:0]        slot_v;
    logic [ADDR_W-1:0] slot_addr [3];
    logic [15:0]       slot_data [2];
    logic [2:0]        gnt_vec;
    grant_t            grant;
    grant_t            last;
    logic              rd_pend;

    assign req_stb     = {disp_stb, cam2_stb, cam1_stb};
    assign req_addr[0] = cam1_addr;
    assign req_addr[1] = cam2_addr;
    assign req_addr[2] = disp_addr;
    assign req_data[0] = cam1_data;
    assign req_data[1] = cam2_data;

    // Round-robin search, starting after the last owner.
    always_comb begin
        grant = GNT_NONE;
        case (last)
            GNT_CAM1: begin
                if (slot_v[1])      grant = GNT_CAM2;
                else if (slot_v[2]) grant = GNT_DISP;
                else if (slot_v[0]) grant = GNT_CAM1;
            end
            GNT_CAM2: begin
                if (slot_v[2])      grant = GNT_DISP;
                else if (slot_v[0]) grant = GNT_CAM1;
                else if (slot_v[1]) grant = GNT_CAM2;
            end
            default: begin
                if (slot_v[0])      grant = GNT_CAM1;
                else if (slot_v[1]) grant = GNT_CAM2;
                else if (slot_v[2]) grant = GNT_DISP;
            end
        endcase
    end

    assign gnt_vec = {grant == GNT_DISP, grant == GNT_CAM2, grant == GNT_CAM1};

    always_comb begin
        mem_we    = 1'b0;
        mem_addr  = slot_addr[0];
        mem_wdata = slot_data[0];
        case (grant)
            GNT_CAM1: mem_we = 1'b1;
            GNT_CAM2: begin
                mem_we    = 1'b1;
                mem_addr  = slot_addr[1];
                mem_wdata = slot_data[1];
            end
            GNT_DISP: mem_addr = slot_addr[2];
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            slot_v   <= '0;
            last     <= GNT_NONE;
            rd_pend  <= 1'b0;
            rd_valid <= 1'b0;
            err      <= 1'b0;
        end else begin
            for (int i = 0; i < 3; i++) begin
                if (req_stb[i]) begin
                    slot_v[i] <= 1'b1;
                end else if (gnt_vec[i]) begin
                    slot_v[i] <= 1'b0;
                end
            end
            if (|(req_stb & slot_v & ~gnt_vec)) begin
                err <= 1'b1;                                      // Sticky until reset.
            end
            if (grant != GNT_NONE) begin
                last <= grant;
            end
            rd_pend  <= (grant == GNT_DISP);                      // RAM output valid next cycle.
            rd_valid <= rd_pend;
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < 3; i++) begin
            if (req_stb[i]) begin
                slot_addr[i] <= req_addr[i];
            end
        end
        for (int i = 0; i < 2; i++) begin
            if (req_stb[i]) begin
                slot_data[i] <= req_data[i];
            end
        end
        if (rd_pend) begin
            rd_data <= mem_rdata;
        end
    end

endmodule : frame_arbiter

`default_nettype wire

// ==== src/frame_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module frame_mem
    import aimbot_pkg::*;
(
    input  wire               clk,
    input  wire               we,
    input  wire  [ADDR_W-1:0] addr,
    input  wire  [15:0]       wdata,
    output logic [15:0]       rdata
);

    logic [15:0] mem [MEM_DEPTH];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];                                       // Old data on a write cycle.
    end

endmodule : frame_mem

`default_nettype wire

// ==== src/video_scanout.sv ====
`timescale 1ns/1ps
`default_nettype none

module video_scanout
    import aimbot_pkg::*;
(
    input  wire               clk,
    input  wire               rst,
    output logic              rd_stb,
    output logic [ADDR_W-1:0] rd_addr,
    input  wire               rd_valid,
    input  wire  [15:0]       rd_data,
    output logic              hsync,
    output logic              vsync,
    output logic              de,
    output logic              pix_stb,
    output logic [7:0]        r,
    output logic [7:0]        g,
    output logic [7:0]        b
);

    logic [$clog2(PIX_DIV)-1:0]         div;
    logic [$clog2(DISP_W+H_BLANK)-1:0]  col;
    logic [$clog2(CAM_H+V_BLANK)-1:0]   line;
    logic                               active;
    logic                               slot_start;
    logic [ADDR_W-1:0]                  addr_now;
    logic [3:0]                         tim_now;
    logic [PIPE_LAT-1:0][3:0]           tim_pipe;
    logic [15:0]                        rd_hold;
    logic [15:0]                        pix_q;

    assign active     = (col < DISP_W) && (line < CAM_H);
    assign slot_start = (div == 0);

    always_comb begin
        if (col < CAM_W) begin
            addr_now = ADDR_W'(line * CAM_W + col);
        end else begin
            addr_now = ADDR_W'(CAM2_BASE + line * CAM_W + col - CAM_W);
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            div  <= '0;
            col  <= '0;
            line <= '0;
        end else begin
            div <= div + 1'b1;
            if (div == PIX_DIV - 1) begin
                div <= '0;
                col <= col + 1'b1;
                if (col == DISP_W + H_BLANK - 1) begin
                    col  <= '0;
                    line <= (line == CAM_H + V_BLANK - 1) ? '0 : line + 1'b1;
                end
            end
        end
    end

    // Flags are {vsync, hsync, de, pix_stb}.
    assign tim_now = {line == CAM_H, col == DISP_W, active, active && slot_start};

    // Display runs PIPE_LAT behind the reads, past the worst read latency.
    always_ff @(posedge clk) begin
        if (rst) begin
            rd_stb   <= 1'b0;
            tim_pipe <= '0;
        end else begin
            rd_stb   <= active && slot_start;
            tim_pipe <= {tim_pipe[PIPE_LAT-2:0], tim_now};
        end
    end

    always_ff @(posedge clk) begin
        if (active && slot_start) begin
            rd_addr <= addr_now;
        end
        if (rd_valid) begin
            rd_hold <= rd_data;
        end
        if (tim_pipe[PIPE_LAT-2][0]) begin                        // Load as the slot opens.
            pix_q <= rd_hold;
        end
    end

    assign {vsync, hsync, de, pix_stb} = tim_pipe[PIPE_LAT-1];

    assign r = {pix_q[15:11], 3'b000};
    assign g = {pix_q[10:5], 2'b00};
    assign b = {pix_q[4:0], 3'b000};

endmodule : video_scanout

`default_nettype wire

// ==== src/aimbot_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module aimbot_top
    import aimbot_pkg::*;
(
    input  wire        clk,
    input  wire        rst,
    input  wire        cam1_vsync,
    input  wire        cam1_byte_valid,
    input  wire  [7:0] cam1_byte_data,
    input  wire        cam2_vsync,
    input  wire        cam2_byte_valid,
    input  wire  [7:0] cam2_byte_data,
    output wire        hsync,
    output wire        vsync,
    output wire        de,
    output wire        pix_stb,
    output wire  [7:0] r,
    output wire  [7:0] g,
    output wire  [7:0] b,
    output wire        err
);

    logic              cam1_stb, cam2_stb, disp_stb;
    logic [ADDR_W-1:0] cam1_addr, cam2_addr, disp_addr;
    logic [15:0]       cam1_data, cam2_data;
    logic              rd_valid;
    logic [15:0]       rd_data;
    logic              mem_we;
    logic [ADDR_W-1:0] mem_addr;
    logic [15:0]       mem_wdata, mem_rdata;

    cam_packer u_cam1_packer (
        .clk        (clk            ),
        .rst        (rst            ),
        .vsync      (cam1_vsync     ),
        .byte_valid (cam1_byte_valid),
        .byte_data  (cam1_byte_data ),
        .region_base('0             ),
        .wr_stb     (cam1_stb       ),
        .wr_addr    (cam1_addr      ),
        .wr_data    (cam1_data      )
    );

    cam_packer u_cam2_packer (
        .clk        (clk              ),
        .rst        (rst              ),
        .vsync      (cam2_vsync       ),
        .byte_valid (cam2_byte_valid  ),
        .byte_data  (cam2_byte_data   ),
        .region_base(ADDR_W'(CAM2_BASE)),
        .wr_stb     (cam2_stb         ),
        .wr_addr    (cam2_addr        ),
        .wr_data    (cam2_data        )
    );

    frame_arbiter u_frame_arbiter (
        .clk      (clk      ),
        .rst      (rst      ),
        .cam1_stb (cam1_stb ),
        .cam1_addr(cam1_addr),
        .cam1_data(cam1_data),
        .cam2_stb (cam2_stb ),
        .cam2_addr(cam2_addr),
        .cam2_data(cam2_data),
        .disp_stb (disp_stb ),
        .disp_addr(disp_addr),
        .rd_valid (rd_valid ),
        .rd_data  (rd_data  ),
        .mem_we   (mem_we   ),
        .mem_addr (mem_addr ),
        .mem_wdata(mem_wdata),
        .mem_rdata(mem_rdata),
        .err      (err      )
    );

    frame_mem u_frame_mem (
        .clk  (clk      ),
        .we   (mem_we   ),
        .addr (mem_addr ),
        .wdata(mem_wdata),
        .rdata(mem_rdata)
    );

    video_scanout u_video_scanout (
        .clk     (clk      ),
        .rst     (rst      ),
        .rd_stb  (disp_stb ),
        .rd_addr (disp_addr),
        .rd_valid(rd_valid ),
        .rd_data (rd_data  ),
        .hsync   (hsync    ),
        .vsync   (vsync    ),
        .de      (de       ),
        .pix_stb (pix_stb  ),
        .r       (r        ),
        .g       (g        ),
        .b       (b        )
    );

endmodule : aimbot_top

`default_nettype wire

// ==== tb/aimbot_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module aimbot_assert
    import aimbot_pkg::*;
(
    input wire              clk,
    input wire              rst,
    input wire              mem_we,
    input wire [ADDR_W-1:0] mem_addr,
    input wire [1:0]        grant,
    input wire              rd_valid,
    input wire              err
);

    // Each camera writes only into its own half of the RAM.
    write_needs_cam_grant: assert property (@(posedge clk) disable iff (rst)
        mem_we |-> ((grant == GNT_CAM1 && mem_addr < CAM2_BASE) ||
                    (grant == GNT_CAM2 && mem_addr >= CAM2_BASE)))
        else $error("mem_we high without a camera grant for that half");

    read_valid_after_grant: assert property (@(posedge clk) disable iff (rst)
        rd_valid == $past(grant == GNT_DISP, 2))
        else $error("rd_valid not two cycles after a display grant");

    err_is_sticky: assert property (@(posedge clk)
        $past(err && !rst) |-> err)
        else $error("err fell while rst was low");

endmodule : aimbot_assert

bind frame_arbiter aimbot_assert u_arbiter_assert (
    .clk     (clk     ),
    .rst     (rst     ),
    .mem_we  (mem_we  ),
    .mem_addr(mem_addr),
    .grant   (grant   ),
    .rd_valid(rd_valid),
    .err     (err     )
);

`default_nettype wire

// ==== tb/aimbot_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module aimbot_tb
    import aimbot_pkg::*;
();

    localparam int NCOL      = 7;                                 // Fields per case line.
    localparam int MAX_CASES = 16;
    localparam int WAIT_MAX  = 2000;
    localparam int DISP_PIX  = DISP_W * CAM_H;

    logic        clk;
    logic        rst;
    logic        cam1_vsync;
    logic        cam1_byte_valid;
    logic [7:0]  cam1_byte_data;
    logic        cam2_vsync;
    logic        cam2_byte_valid;
    logic [7:0]  cam2_byte_data;
    wire         hsync;
    wire         vsync;
    wire         de;
    wire         pix_stb;
    wire  [7:0]  r;
    wire  [7:0]  g;
    wire  [7:0]  b;
    wire         err;

    logic [31:0] case_mem [MAX_CASES*NCOL];
    logic [15:0] cam1_pix [FRAME_PIX];
    logic [15:0] cam2_pix [FRAME_PIX];
    int          errors;
    int          case_errors;
    int          cases_run;
    int          cases_passed;
    logic        timed_out;

    aimbot_top uut (
        .clk            (clk            ),
        .rst            (rst            ),
        .cam1_vsync     (cam1_vsync     ),
        .cam1_byte_valid(cam1_byte_valid),
        .cam1_byte_data (cam1_byte_data ),
        .cam2_vsync     (cam2_vsync     ),
        .cam2_byte_valid(cam2_byte_valid),
        .cam2_byte_data (cam2_byte_data ),
        .hsync          (hsync          ),
        .vsync          (vsync          ),
        .de             (de             ),
        .pix_stb        (pix_stb        ),
        .r              (r              ),
        .g              (g              ),
        .b              (b              ),
        .err            (err            )
    );

    initial begin
        clk = 1'b0;
        forever begin
            #2 clk = ~clk;
        end
    end

    task automatic report_mismatch(input string name, input logic [15:0] got,
                                   input logic [15:0] exp);
        $display("Mismatch at %0t: %s is %h, expected %h", $time, name, got, exp);
        errors++;
        case_errors++;
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t: waited %0d cycles for %s", $time, WAIT_MAX, what);
        timed_out = 1'b1;
        errors++;
        case_errors++;
    endtask

    // One clock, sampled at the drive point after the edge.
    task automatic advance_cycle(inout int n, input string what);
        @(posedge clk);
        #1;
        n++;
        if (n >= WAIT_MAX) begin
            report_timeout(what);
        end
    endtask

    task automatic wait_frame_start();
        int n;
        n = 0;
        while (vsync && !timed_out) begin
            advance_cycle(n, "end of display vsync");
        end
        n = 0;
        while (!vsync && !timed_out) begin
            advance_cycle(n, "display vsync");
        end
        n = 0;
        while (!de && !timed_out) begin
            advance_cycle(n, "first de of the frame");
        end
    endtask

    task automatic fill_expected(input logic [15:0] base1, input logic [15:0] base2,
                                 input logic [15:0] inc);
        for (int i = 0; i < FRAME_PIX; i++) begin
            cam1_pix[i] = 16'(base1 + i * inc);                   // Wraps modulo 2^16.
            cam2_pix[i] = 16'(base2 + i * inc);
        end
    endtask

    task automatic send_frames(input int gap, input int extra);
        int          idle;
        logic [15:0] p1;
        logic [15:0] p2;
        @(posedge clk);
        #1;
        cam1_vsync = 1'b1;
        cam2_vsync = 1'b1;
        @(posedge clk);
        #1;
        cam1_vsync = 1'b0;
        cam2_vsync = 1'b0;
        for (int i = 0; i < FRAME_PIX; i++) begin
            p1 = cam1_pix[i];
            p2 = cam2_pix[i];
            for (int j = 0; j < 2; j++) begin
                idle = gap;
                if (extra > 0) begin
                    idle = gap + int'($urandom_range(extra, 0));
                end
                @(posedge clk);
                #1;
                cam1_byte_valid = 1'b1;
                cam2_byte_valid = 1'b1;
                cam1_byte_data  = (j == 0) ? p1[15:8] : p1[7:0];  // High byte first.
                cam2_byte_data  = (j == 0) ? p2[15:8] : p2[7:0];
                repeat (idle) begin
                    @(posedge clk);
                    #1;
                    cam1_byte_valid = 1'b0;
                    cam2_byte_valid = 1'b0;
                end
            end
        end
        @(posedge clk);
        #1;
        cam1_byte_valid = 1'b0;
        cam2_byte_valid = 1'b0;
    endtask

    task automatic check_pixel(input int x, input int y);
        logic [15:0] p;
        logic [7:0]  exp_r;
        logic [7:0]  exp_g;
        logic [7:0]  exp_b;
        if (x < CAM_W) begin
            p = cam1_pix[y * CAM_W + x];
        end else begin
            p = cam2_pix[y * CAM_W + x - CAM_W];
        end
        exp_r = 8'(p[15:11]) << 3;
        exp_g = 8'(p[10:5]) << 2;
        exp_b = 8'(p[4:0]) << 3;
        if (r !== exp_r) begin
            report_mismatch($sformatf("r at (%0d,%0d)", x, y), 16'(r), 16'(exp_r));
        end
        if (g !== exp_g) begin
            report_mismatch($sformatf("g at (%0d,%0d)", x, y), 16'(g), 16'(exp_g));
        end
        if (b !== exp_b) begin
            report_mismatch($sformatf("b at (%0d,%0d)", x, y), 16'(b), 16'(exp_b));
        end
    endtask

    // Starts at the first de of a frame and runs to the next vsync.
    task automatic capture_frame(input logic check_pix);
        int   n;
        int   line_pix;
        int   de_cyc;
        int   lines;
        int   total;
        logic hs_q;
        n        = 0;
        line_pix = 0;
        de_cyc   = 0;
        lines    = 0;
        total    = 0;
        hs_q     = hsync;
        while (!vsync && !timed_out) begin
            if (pix_stb) begin
                if (check_pix && line_pix < DISP_W && lines < CAM_H) begin
                    check_pixel(line_pix, lines);
                end
                line_pix++;
                total++;
            end
            if (de) begin
                de_cyc++;
            end
            if (hsync && !hs_q) begin
                if (line_pix != DISP_W) begin
                    report_mismatch("de slots per line", 16'(line_pix), 16'(DISP_W));
                end
                if (de_cyc != DISP_W * PIX_DIV) begin
                    report_mismatch("de cycles per line", 16'(de_cyc),
                                    16'(DISP_W * PIX_DIV));
                end
                lines++;
                line_pix = 0;
                de_cyc   = 0;
            end
            hs_q = hsync;
            advance_cycle(n, "display vsync after the active lines");
        end
        if (!timed_out && lines != CAM_H) begin
            report_mismatch("active lines", 16'(lines), 16'(CAM_H));
        end
        if (!timed_out && total != DISP_PIX) begin
            report_mismatch("pix_stb count", 16'(total), 16'(DISP_PIX));
        end
    endtask

    task automatic pulse_reset();
        @(posedge clk);
        #1;
        rst = 1'b1;
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;
        @(posedge clk);
        #1;
    endtask

    initial begin
        int          base;
        int          id;
        int          gap;
        int          extra;
        logic        exp_err;
        rst             = 1'b1;
        cam1_vsync      = 1'b0;
        cam1_byte_valid = 1'b0;
        cam1_byte_data  = 8'h00;
        cam2_vsync      = 1'b0;
        cam2_byte_valid = 1'b0;
        cam2_byte_data  = 8'h00;
        errors          = 0;
        cases_run       = 0;
        cases_passed    = 0;
        timed_out       = 1'b0;
        void'($urandom(32'he7155f02));
        for (int i = 0; i < MAX_CASES * NCOL; i++) begin
            case_mem[i] = '1;                                     // Marks unused lines.
        end
        $readmemh("tb/aimbot_cases.txt", case_mem);
        repeat (5) @(posedge clk);
        #1;
        rst = 1'b0;

        for (int k = 0; k < MAX_CASES; k++) begin
            base = k * NCOL;
            if (case_mem[base] === '1 || timed_out) begin
                break;
            end
            id          = int'(case_mem[base]);
            gap         = int'(case_mem[base + 1]);
            exp_err     = case_mem[base + 5][0];
            extra       = int'(case_mem[base + 6]);
            case_errors = 0;
            fill_expected(case_mem[base + 2][15:0], case_mem[base + 3][15:0],
                          case_mem[base + 4][15:0]);
            wait_frame_start();                                   // Writes overlap active video.
            if (!timed_out) begin
                send_frames(gap, extra);
            end
            wait_frame_start();
            capture_frame(!exp_err);
            if (!timed_out && err !== exp_err) begin
                report_mismatch("err", 16'(err), 16'(exp_err));
            end
            if (!timed_out && exp_err) begin
                pulse_reset();
                if (err !== 1'b0) begin
                    report_mismatch("err after reset", 16'(err), 16'h0000);
                end
            end
            cases_run++;
            if (case_errors == 0) begin
                cases_passed++;
            end
            $display("Case %0d (gap %0d, extra %0d): %s, %0d errors", id, gap, extra,
                     (case_errors == 0) ? "pass" : "fail", case_errors);
        end

        $display("Summary: %0d cases run, %0d passed, %0d failed, %0d errors",
                 cases_run, cases_passed, cases_run - cases_passed, errors);
        if (errors == 0 && !timed_out && cases_run > 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule : aimbot_tb

`default_nettype wire

// ==== tb/aimbot_cases.txt ====
// case gap base1 base2 incr err extra, all hex; gap is idle cycles between byte strobes
// extra is the largest random idle added per byte step, 0 for none
1 2 18e3 e71c 0841 0 0
2 2 ffff 0000 1357 0 0
3 2 39e7 c618 0421 0 3
4 4 7bef 8410 fedc 0 0
5 1 a5a5 5a5a 0101 0 0
6 0 1234 4321 0003 1 0

// ==== aimbot_top.f ====
src/aimbot_pkg.sv
src/cam_packer.sv
src/frame_arbiter.sv
src/frame_mem.sv
src/video_scanout.sv
src/aimbot_top.sv
tb/aimbot_assert.sv
tb/aimbot_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing --assert -Wno-fatal --top-module aimbot_tb \
    -f aimbot_top.f -o aimbot_sim > build.log 2>&1 \
    || { cat build.log; echo "Build failed"; exit 1; }
./obj_dir/aimbot_sim > sim.log 2>&1
cat sim.log
grep -qx "TEST PASSED" sim.log && echo "Simulation passed" \
    || { echo "Simulation failed"; exit 1; }
